//--- project.f
dispatch_pkg.sv
wb_if.sv
gpr_file.sv
free_run_counter.sv
sysreg_file.sv
operand_fetch.sv
dispatch_top.sv
tb_clock.sv
tb_dispatch.sv

//--- Bender.yml
package:
  name: dispatch_stage

sources:
  - dispatch_pkg.sv
  - wb_if.sv
  - gpr_file.sv
  - free_run_counter.sv
  - sysreg_file.sv
  - operand_fetch.sv
  - dispatch_top.sv
  - target: test
    files:
      - tb_clock.sv
      - tb_dispatch.sv

//--- tb_dispatch.sv
module tb_dispatch import dispatch_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CORE_ID = 3;
	// Tests take a few hundred cycles, this leaves a wide margin
	localparam int CYCLE_LIMIT = 2000;
	localparam word_t IRQ_CLEAR = (32'd1 << 6) | (32'd1 << 5) | (32'd1 << 2);

	logic iCLOCK, inRESET;
	logic refresh, irq_set, irq_clr, next_lock, prev_lock;
	logic wb_valid, wb_dest_sysreg, wb_writeback, wb_spr_writeback, wb_branch, wb_pipeline_stop;
	word_t wb_data, wb_spr, wb_pc, wb_branch_pc;
	reg_ptr_t wb_destination;
	logic prev_valid, prev_src0_sysreg, prev_src1_sysreg, prev_src1_imm;
	logic prev_dest_sysreg, prev_writeback, prev_branch;
	reg_ptr_t prev_src0, prev_dest, next_dest;
	word_t prev_src1, prev_pc;
	cmd_t prev_cmd, next_cmd;
	cc_t prev_cc, next_cc;
	logic next_valid, next_dest_sysreg, next_writeback, exception_lock;
	word_t next_source0, next_source1, next_pc, psr, ppsr, spr, tidr, pcr;

	word_t gpr_model [32];
	word_t psr_model, ppsr_model, spr_model, tidr_model, pcr_model;
	logic pcv_model;
	logic chk_src;
	word_t exp_src0, exp_src1, exp_pc;
	logic [15:0] exp_fields;
	logic exp_branch;
	string test_name;
	int cycles = 0, wr_cycle, value_errors, other_errors;
	logic [31:0] lfsr;
	word_t w, w2, pc;
	reg_ptr_t p, q;
	counter_t v_load, snap;
	int t_load;

	tb_clock u_clock (.iCLOCK(iCLOCK), .inRESET(inRESET));

	dispatch_top #(.CORE_ID(CORE_ID)) u_dut (.*);

	// x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic word_t rand_bits(input int n);
		word_t v;
		logic  fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	task automatic report_value(input string what, input word_t exp, input word_t act);
		value_errors++;
		$display("ERROR %s %s: expected %h actual %h", test_name, what, exp, act);
	endtask

	task automatic report_fault(input string msg);
		other_errors++;
		$display("ERROR %s: %s", test_name, msg);
	endtask

	task automatic clear_inputs();
		refresh <= 1'b0;
		irq_set <= 1'b0;
		irq_clr <= 1'b0;
		wb_valid <= 1'b0;
		wb_spr_writeback <= 1'b0;
		wb_pipeline_stop <= 1'b0;
		prev_valid <= 1'b0;
	endtask

	task automatic set_wb(input logic sys, input reg_ptr_t dest, input word_t data,
			input logic stop);
		wb_valid <= 1'b1;
		wb_writeback <= 1'b1;
		wb_dest_sysreg <= sys;
		wb_destination <= dest;
		wb_data <= data;
		wb_pipeline_stop <= stop;
		wb_pc <= rand_bits(32);
		wb_branch <= rand_bits(1);
		wb_branch_pc <= rand_bits(32);
	endtask

	task automatic set_inst(input reg_ptr_t s0, input logic s0_sys, input word_t s1,
			input logic s1_sys, input logic s1_imm, input word_t ipc);
		prev_valid <= 1'b1;
		prev_src0 <= s0;
		prev_src0_sysreg <= s0_sys;
		prev_src1 <= s1;
		prev_src1_sysreg <= s1_sys;
		prev_src1_imm <= s1_imm;
		prev_pc <= ipc;
		prev_dest <= rand_bits(5);
		prev_cmd <= rand_bits(5);
		prev_cc <= rand_bits(4);
		prev_dest_sysreg <= rand_bits(1);
		prev_writeback <= rand_bits(1);
		prev_branch <= rand_bits(1);
	endtask

	// Called on the edge that drives the instruction
	task automatic dispatch(input word_t e0, input word_t e1);
		@(posedge iCLOCK);
		clear_inputs();
		chk_src <= 1'b1;
		exp_src0 <= e0;
		exp_src1 <= e1;
		exp_pc <= prev_pc;
		exp_fields <= {prev_dest, prev_cmd, prev_cc, prev_dest_sysreg, prev_writeback};
		exp_branch <= prev_branch;
		@(posedge iCLOCK);
		chk_src <= 1'b0;
	endtask

	task automatic write_reg(input logic sys, input reg_ptr_t dest, input word_t data);
		@(posedge iCLOCK);
		set_wb(sys, dest, data, 1'b0);
		wr_cycle = cycles;
		@(posedge iCLOCK);
		clear_inputs();
	endtask

	task automatic pulse_irq(input logic s, input logic c);
		@(posedge iCLOCK);
		irq_set <= s;
		irq_clr <= c;
		@(posedge iCLOCK);
		clear_inputs();
	endtask

	// Architectural state from the writeback and interrupt rules
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < 32; i++) begin
				gpr_model[i] <= '0;
			end
			psr_model <= '0;
			ppsr_model <= '0;
			spr_model <= '0;
			tidr_model <= '0;
			pcr_model <= '0;
		end else if (wb_valid && !wb_pipeline_stop) begin
			if (wb_writeback && !wb_dest_sysreg) begin
				gpr_model[wb_destination] <= wb_data;
			end
			if (wb_spr_writeback) begin
				spr_model <= wb_spr;
			end else if (wb_writeback && wb_dest_sysreg && wb_destination == SYSREG_SPR) begin
				spr_model <= wb_data;
			end
			if (wb_writeback && wb_dest_sysreg && wb_destination == SYSREG_PSR) begin
				psr_model <= wb_data;
			end
			if (wb_writeback && wb_dest_sysreg && wb_destination == SYSREG_PPSR) begin
				ppsr_model <= wb_data;
			end
			if (wb_writeback && wb_dest_sysreg && wb_destination == SYSREG_TIDR) begin
				tidr_model <= wb_data;
			end
			if (wb_branch) begin
				pcr_model <= wb_branch_pc;
			end else begin
				pcr_model <= wb_pc;
			end
		end else if (irq_set) begin
			psr_model <= psr_model & ~IRQ_CLEAR;
			ppsr_model <= psr_model;
		end else if (irq_clr) begin
			psr_model <= ppsr_model;
		end
	end

	// PC becomes known on the first retired writeback, refresh forgets it
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pcv_model <= 1'b0;
		end else if (refresh) begin
			pcv_model <= 1'b0;
		end else if (wb_valid && !wb_pipeline_stop) begin
			pcv_model <= 1'b1;
		end
	end

	always_ff @(posedge iCLOCK) begin
		cycles <= cycles + 1;
		if (cycles == CYCLE_LIMIT) begin
			$display("Run stopped at the cycle limit of %0d", CYCLE_LIMIT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	a_reset_state: assert property (@(posedge iCLOCK) $rose(inRESET) |-> !next_valid && exception_lock)
		else report_fault("stage not empty or exception_lock low after reset");
	a_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET) chk_src |-> next_valid)
		else report_value("next_valid", 32'd1, word_t'($sampled(next_valid)));
	a_src0: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		chk_src |-> next_source0 == exp_src0)
		else report_value("source0", $sampled(exp_src0), $sampled(next_source0));
	a_src1: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		chk_src |-> next_source1 == exp_src1)
		else report_value("source1", $sampled(exp_src1), $sampled(next_source1));
	a_pc: assert property (@(posedge iCLOCK) disable iff (!inRESET) chk_src |-> next_pc == exp_pc)
		else report_value("pc", $sampled(exp_pc), $sampled(next_pc));
	a_fields: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		chk_src |-> {next_dest, next_cmd, next_cc, next_dest_sysreg, next_writeback} == exp_fields)
		else report_value("dest/cmd/cc/flags", word_t'($sampled(exp_fields)),
			word_t'($sampled({next_dest, next_cmd, next_cc, next_dest_sysreg, next_writeback})));
	a_elock: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		chk_src |-> exception_lock == (!pcv_model || exp_branch))
		else report_value("exception_lock", word_t'($sampled(!pcv_model || exp_branch)),
			word_t'($sampled(exception_lock)));
	a_psr: assert property (@(posedge iCLOCK) disable iff (!inRESET) psr == psr_model)
		else report_value("psr", $sampled(psr_model), $sampled(psr));
	a_ppsr: assert property (@(posedge iCLOCK) disable iff (!inRESET) ppsr == ppsr_model)
		else report_value("ppsr", $sampled(ppsr_model), $sampled(ppsr));
	a_spr: assert property (@(posedge iCLOCK) disable iff (!inRESET) spr == spr_model)
		else report_value("spr", $sampled(spr_model), $sampled(spr));
	a_tidr: assert property (@(posedge iCLOCK) disable iff (!inRESET) tidr == tidr_model)
		else report_value("tidr", $sampled(tidr_model), $sampled(tidr));
	a_pcr: assert property (@(posedge iCLOCK) disable iff (!inRESET) pcr == pcr_model)
		else report_value("pcr", $sampled(pcr_model), $sampled(pcr));
	a_prev_lock: assert property (@(posedge iCLOCK) disable iff (!inRESET) prev_lock == next_lock)
		else report_fault("prev_lock does not follow next_lock");
	a_lock_valid: assert property (@(posedge iCLOCK) disable iff (!inRESET) next_lock |-> !next_valid)
		else report_fault("next_valid high while next_lock is high");
	a_hold: assert property (@(posedge iCLOCK) disable iff (!inRESET) next_lock && !refresh
		|=> $stable(next_source0) && $stable(next_source1) && $stable(next_pc))
		else report_fault("stage outputs changed while locked");
	a_refresh: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		refresh |=> !next_valid && exception_lock)
		else report_fault("refresh did not empty the stage");

	initial begin
		lfsr = 32'hb3ad_a515;
		value_errors = 0;
		other_errors = 0;
		chk_src = 1'b0;
		exp_fields = '0;
		exp_branch = 1'b0;
		next_lock = 1'b0;
		{wb_writeback, wb_dest_sysreg, wb_branch} = '0;
		{wb_data, wb_spr, wb_pc, wb_branch_pc, wb_destination} = '0;
		{prev_src0_sysreg, prev_src1_sysreg, prev_src1_imm} = '0;
		{prev_dest_sysreg, prev_writeback, prev_branch} = '0;
		{prev_src0, prev_src1, prev_dest, prev_cmd, prev_cc, prev_pc} = '0;
		clear_inputs();
		wait (inRESET === 1'b1);

		test_name = "reset";
		@(posedge iCLOCK);
		set_inst(SYSREG_CPUIDR, 1'b1, word_t'(SYSREG_COREIDR), 1'b1, 1'b0, 32'h100);
		dispatch(PROCESSOR_ID_REV, word_t'(CORE_ID));

		test_name = "register";
		for (int i = 0; i < 8; i++) begin
			p = rand_bits(5);
			q = rand_bits(5);
			w = rand_bits(32);
			w2 = rand_bits(32);
			write_reg(1'b0, p, w);
			@(posedge iCLOCK);
			pc = rand_bits(30) << 2;
			if (i % 2 == 0) begin
				set_inst(p, 1'b0, w2, 1'b0, 1'b1, pc);
				dispatch(w, w2);
			end else begin
				set_inst(p, 1'b0, word_t'(q), 1'b0, 1'b0, pc);
				dispatch(w, gpr_model[q]);
			end
			@(posedge iCLOCK);
			set_inst(SYSREG_PCR, 1'b1, w2, 1'b0, 1'b1, pc);
			dispatch(pc - 32'd4, w2);
		end
		w = rand_bits(32);
		write_reg(1'b1, SYSREG_TIDR, w);
		@(posedge iCLOCK);
		set_inst(SYSREG_TIDR, 1'b1, '0, 1'b0, 1'b1, 32'h180);
		dispatch(w, '0);

		test_name = "forward";
		p = rand_bits(5);
		w = rand_bits(32);
		w2 = rand_bits(32);
		@(posedge iCLOCK);
		set_wb(1'b0, p, w, 1'b0);
		set_inst(p, 1'b0, '0, 1'b0, 1'b1, 32'h200);
		dispatch(w, '0);
		// Stalled writeback is neither bypassed nor stored
		set_wb(1'b0, p, w2, 1'b1);
		set_inst(p, 1'b0, '0, 1'b0, 1'b1, 32'h204);
		dispatch(w, '0);
		set_inst(p, 1'b0, '0, 1'b0, 1'b1, 32'h208);
		dispatch(gpr_model[p], '0);

		test_name = "lock";
		@(posedge iCLOCK);
		set_inst(p, 1'b0, 32'h1111, 1'b0, 1'b1, 32'h300);
		@(posedge iCLOCK);
		next_lock <= 1'b1;
		set_inst(p, 1'b0, 32'h2222, 1'b0, 1'b1, 32'h304);
		repeat (5) @(posedge iCLOCK);
		next_lock <= 1'b0;
		dispatch(gpr_model[p], 32'h2222);
		set_inst(p, 1'b0, 32'h3333, 1'b0, 1'b1, 32'h308);
		@(posedge iCLOCK);
		refresh <= 1'b1;
		@(posedge iCLOCK);
		clear_inputs();

		test_name = "irq";
		w = rand_bits(32) | IRQ_CLEAR;
		write_reg(1'b1, SYSREG_PSR, w);
		pulse_irq(1'b1, 1'b0);
		@(posedge iCLOCK);
		set_inst(SYSREG_PSR, 1'b1, word_t'(SYSREG_PPSR), 1'b1, 1'b0, 32'h400);
		dispatch(w & ~IRQ_CLEAR, w);
		pulse_irq(1'b0, 1'b1);
		w = rand_bits(32);
		w2 = rand_bits(32);
		write_reg(1'b1, SYSREG_SPR, w);
		@(posedge iCLOCK);
		set_wb(1'b1, SYSREG_SPR, w, 1'b0);
		wb_spr_writeback <= 1'b1;
		wb_spr <= w2;
		@(posedge iCLOCK);
		clear_inputs();
		@(posedge iCLOCK);
		set_inst(SYSREG_SPR, 1'b1, '0, 1'b0, 1'b1, 32'h404);
		dispatch(w2, '0);

		test_name = "counter";
		// Low half at the top so the count carries into the high half
		v_load = {rand_bits(32), rand_bits(2) | 32'hffff_fffc};
		write_reg(1'b1, SYSREG_FRCLR, v_load[31:0]);
		write_reg(1'b1, SYSREG_FRCHR, v_load[63:32]);
		write_reg(1'b1, SYSREG_FRCR, '0);
		t_load = wr_cycle;
		for (int i = 0; i < 2; i++) begin
			repeat (rand_bits(4) + 3) @(posedge iCLOCK);
			write_reg(1'b1, SYSREG_FRCR2FRCXR, '0);
			// Snapshot holds the count from one edge before its commit
			snap = v_load + counter_t'(wr_cycle - t_load - 1);
			@(posedge iCLOCK);
			set_inst(SYSREG_FRCLR, 1'b1, word_t'(SYSREG_FRCHR), 1'b1, 1'b0, 32'h500);
			dispatch(snap[31:0], snap[63:32]);
		end

		repeat (3) @(posedge iCLOCK);
		$display("Error count: %0d value, %0d other", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- tb_clock.sv
module tb_clock (
	output logic iCLOCK,
	output logic inRESET
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		iCLOCK = 1'b0;
		forever begin
			#2 iCLOCK = ~iCLOCK;
		end
	end

	// Held low for the first 10 rising edges
	initial begin
		inRESET = 1'b0;
		repeat (10) @(posedge iCLOCK);
		inRESET <= 1'b1;
	end

endmodule

//--- dispatch_top.sv
module dispatch_top import dispatch_pkg::*; #(
	parameter int CORE_ID = 0
) (
	input  logic     iCLOCK,
	input  logic     inRESET,
	input  logic     refresh,
	input  logic     irq_set,
	input  logic     irq_clr,
	input  logic     wb_valid,
	input  word_t    wb_data,
	input  reg_ptr_t wb_destination,
	input  logic     wb_dest_sysreg,
	input  logic     wb_writeback,
	input  logic     wb_spr_writeback,
	input  word_t    wb_spr,
	input  word_t    wb_pc,
	input  logic     wb_branch,
	input  word_t    wb_branch_pc,
	input  logic     wb_pipeline_stop,
	input  logic     prev_valid,
	input  logic     prev_src0_sysreg,
	input  logic     prev_src1_sysreg,
	input  logic     prev_src1_imm,
	input  logic     prev_dest_sysreg,
	input  logic     prev_writeback,
	input  logic     prev_branch,
	input  reg_ptr_t prev_src0,
	input  word_t    prev_src1,
	input  reg_ptr_t prev_dest,
	input  cmd_t     prev_cmd,
	input  cc_t      prev_cc,
	input  word_t    prev_pc,
	output logic     prev_lock,
	input  logic     next_lock,
	output logic     next_valid,
	output word_t    next_source0,
	output word_t    next_source1,
	output word_t    next_pc,
	output reg_ptr_t next_dest,
	output cmd_t     next_cmd,
	output cc_t      next_cc,
	output logic     next_dest_sysreg,
	output logic     next_writeback,
	output logic     exception_lock,
	output word_t    psr,
	output word_t    ppsr,
	output word_t    spr,
	output word_t    tidr,
	output word_t    pcr
);

	reg_ptr_t gpr_rd0_ptr;
	reg_ptr_t gpr_rd1_ptr;
	word_t    gpr_rd0_data;
	word_t    gpr_rd1_data;
	reg_ptr_t sys_rd0_ptr;
	reg_ptr_t sys_rd1_ptr;
	word_t    sys_rd0_data;
	word_t    sys_rd1_data;
	logic     sys_rd0_hit;
	logic     sys_rd1_hit;
	word_t    inst_pc;

	wb_if wb ();

	assign wb.valid         = wb_valid;
	assign wb.data          = wb_data;
	assign wb.destination   = wb_destination;
	assign wb.dest_sysreg   = wb_dest_sysreg;
	assign wb.writeback     = wb_writeback;
	assign wb.spr_writeback = wb_spr_writeback;
	assign wb.spr           = wb_spr;
	assign wb.pc            = wb_pc;
	assign wb.branch        = wb_branch;
	assign wb.branch_pc     = wb_branch_pc;
	assign wb.pipeline_stop = wb_pipeline_stop;

	gpr_file u_gpr (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.wb       (wb.sink),
		.rd0_ptr  (gpr_rd0_ptr),
		.rd1_ptr  (gpr_rd1_ptr),
		.rd0_data (gpr_rd0_data),
		.rd1_data (gpr_rd1_data)
	);

	sysreg_file #(
		.CORE_ID (CORE_ID)
	) u_sysreg (
		.iCLOCK   (iCLOCK),
		.inRESET  (inRESET),
		.wb       (wb.sink),
		.irq_set  (irq_set),
		.irq_clr  (irq_clr),
		.inst_pc  (inst_pc),
		.rd0_ptr  (sys_rd0_ptr),
		.rd1_ptr  (sys_rd1_ptr),
		.rd0_data (sys_rd0_data),
		.rd1_data (sys_rd1_data),
		.rd0_hit  (sys_rd0_hit),
		.rd1_hit  (sys_rd1_hit),
		.psr      (psr),
		.ppsr     (ppsr),
		.spr      (spr),
		.tidr     (tidr),
		.pcr      (pcr)
	);

	operand_fetch u_fetch (
		.iCLOCK           (iCLOCK),
		.inRESET          (inRESET),
		.wb               (wb.bypass),
		.refresh          (refresh),
		.prev_valid       (prev_valid),
		.prev_src0_sysreg (prev_src0_sysreg),
		.prev_src1_sysreg (prev_src1_sysreg),
		.prev_src1_imm    (prev_src1_imm),
		.prev_dest_sysreg (prev_dest_sysreg),
		.prev_writeback   (prev_writeback),
		.prev_branch      (prev_branch),
		.prev_src0        (prev_src0),
		.prev_src1        (prev_src1),
		.prev_dest        (prev_dest),
		.prev_cmd         (prev_cmd),
		.prev_cc          (prev_cc),
		.prev_pc          (prev_pc),
		.next_lock        (next_lock),
		.prev_lock        (prev_lock),
		.gpr_rd0_ptr      (gpr_rd0_ptr),
		.gpr_rd1_ptr      (gpr_rd1_ptr),
		.gpr_rd0_data     (gpr_rd0_data),
		.gpr_rd1_data     (gpr_rd1_data),
		.sys_rd0_ptr      (sys_rd0_ptr),
		.sys_rd1_ptr      (sys_rd1_ptr),
		.sys_rd0_data     (sys_rd0_data),
		.sys_rd1_data     (sys_rd1_data),
		.sys_rd0_hit      (sys_rd0_hit),
		.sys_rd1_hit      (sys_rd1_hit),
		.inst_pc          (inst_pc),
		.next_valid       (next_valid),
		.next_source0     (next_source0),
		.next_source1     (next_source1),
		.next_pc          (next_pc),
		.next_dest        (next_dest),
		.next_cmd         (next_cmd),
		.next_cc          (next_cc),
		.next_dest_sysreg (next_dest_sysreg),
		.next_writeback   (next_writeback),
		.exception_lock   (exception_lock)
	);

endmodule

//--- operand_fetch.sv
module operand_fetch import dispatch_pkg::*; (
	input  logic     iCLOCK,
	input  logic     inRESET,
	wb_if.bypass     wb,
	input  logic     refresh,
	input  logic     prev_valid,
	input  logic     prev_src0_sysreg,
	input  logic     prev_src1_sysreg,
	input  logic     prev_src1_imm,
	input  logic     prev_dest_sysreg,
	input  logic     prev_writeback,
	input  logic     prev_branch,
	input  reg_ptr_t prev_src0,
	input  word_t    prev_src1,
	input  reg_ptr_t prev_dest,
	input  cmd_t     prev_cmd,
	input  cc_t      prev_cc,
	input  word_t    prev_pc,
	input  logic     next_lock,
	output logic     prev_lock,
	output reg_ptr_t gpr_rd0_ptr,
	output reg_ptr_t gpr_rd1_ptr,
	input  word_t    gpr_rd0_data,
	input  word_t    gpr_rd1_data,
	output reg_ptr_t sys_rd0_ptr,
	output reg_ptr_t sys_rd1_ptr,
	input  word_t    sys_rd0_data,
	input  word_t    sys_rd1_data,
	input  logic     sys_rd0_hit,
	input  logic     sys_rd1_hit,
	output word_t    inst_pc,
	output logic     next_valid,
	output word_t    next_source0,
	output word_t    next_source1,
	output word_t    next_pc,
	output reg_ptr_t next_dest,
	output cmd_t     next_cmd,
	output cc_t      next_cc,
	output logic     next_dest_sysreg,
	output logic     next_writeback,
	output logic     exception_lock
);

	logic        commit;
	logic [32:0] fwd0;
	logic [32:0] fwd1;
	word_t       src0_val;
	word_t       src1_val;
	logic        stage_valid;
	logic        stage_branch;
	logic        pc_valid;

	assign commit = wb.valid && !wb.pipeline_stop;

	assign gpr_rd0_ptr = prev_src0;
	assign gpr_rd1_ptr = prev_src1[4:0];
	assign sys_rd0_ptr = prev_src0;
	assign sys_rd1_ptr = prev_src1[4:0];
	assign inst_pc     = prev_pc;

	function automatic logic [32:0] fwd_sel(input reg_ptr_t ptr, input logic is_sys);
		logic [32:0] res;
		res = '0;
		if (commit) begin
			if (is_sys) begin
				if (wb.spr_writeback && ptr == SYSREG_SPR) begin
					res = {1'b1, wb.spr};
				end else if (wb.dest_sysreg && ptr == SYSREG_PCR) begin
					res = {1'b1, wb.pc};
				end else if (wb.dest_sysreg && wb.writeback && ptr == wb.destination) begin
					res = {1'b1, wb.data};
				end
			end else if (!wb.dest_sysreg && wb.writeback && ptr == wb.destination) begin
				res = {1'b1, wb.data};
			end
		end
		return res;
	endfunction

	// Immediate, then bypass, then system register, then GPR
	always_comb begin
		fwd0 = fwd_sel(prev_src0, prev_src0_sysreg);
		fwd1 = fwd_sel(prev_src1[4:0], prev_src1_sysreg);
		if (fwd0[32]) begin
			src0_val = fwd0[31:0];
		end else if (prev_src0_sysreg && sys_rd0_hit) begin
			src0_val = sys_rd0_data;
		end else begin
			src0_val = gpr_rd0_data;
		end
		if (prev_src1_imm) begin
			src1_val = prev_src1;
		end else if (fwd1[32]) begin
			src1_val = fwd1[31:0];
		end else if (prev_src1_sysreg && sys_rd1_hit) begin
			src1_val = sys_rd1_data;
		end else begin
			src1_val = gpr_rd1_data;
		end
	end

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET || refresh) begin
			stage_valid      <= 1'b0;
			stage_branch     <= 1'b0;
			next_dest_sysreg <= 1'b0;
			next_writeback   <= 1'b0;
			next_dest        <= '0;
			next_cmd         <= '0;
			next_cc          <= '0;
			next_source0     <= '0;
			next_source1     <= '0;
			next_pc          <= '0;
		end else if (!next_lock) begin
			stage_valid      <= prev_valid;
			stage_branch     <= prev_branch;
			next_dest_sysreg <= prev_dest_sysreg;
			next_writeback   <= prev_writeback;
			next_dest        <= prev_dest;
			next_cmd         <= prev_cmd;
			next_cc          <= prev_cc;
			next_source0     <= src0_val;
			next_source1     <= src1_val;
			next_pc          <= prev_pc;
		end
	end

	// PC known once the first writeback has retired
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			pc_valid <= 1'b0;
		end else if (refresh) begin
			pc_valid <= 1'b0;
		end else if (commit) begin
			pc_valid <= 1'b1;
		end
	end

	assign next_valid     = stage_valid && !next_lock;
	assign prev_lock      = next_lock;
	assign exception_lock = !pc_valid || !stage_valid || stage_branch;

	a_prev_valid_known: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!$isunknown(prev_valid)
	);

endmodule

//--- sysreg_file.sv
module sysreg_file import dispatch_pkg::*; #(
	parameter int CORE_ID = 0
) (
	input  logic     iCLOCK,
	input  logic     inRESET,
	wb_if.sink       wb,
	input  logic     irq_set,
	input  logic     irq_clr,
	input  word_t    inst_pc,
	input  reg_ptr_t rd0_ptr,
	input  reg_ptr_t rd1_ptr,
	output word_t    rd0_data,
	output word_t    rd1_data,
	output logic     rd0_hit,
	output logic     rd1_hit,
	output word_t    psr,
	output word_t    ppsr,
	output word_t    spr,
	output word_t    tidr,
	output word_t    pcr
);

	localparam word_t CORE_IDR = word_t'(CORE_ID);

	logic     commit;
	logic     sys_wr;
	logic     wr_frcr;
	logic     wr_snap;
	word_t    frclr;
	word_t    frchr;
	word_t    pc_read;
	counter_t count;

	assign commit  = wb.valid && !wb.pipeline_stop;
	assign sys_wr  = commit && wb.writeback && wb.dest_sysreg;
	assign wr_frcr = sys_wr && wb.destination == SYSREG_FRCR;
	assign wr_snap = sys_wr && wb.destination == SYSREG_FRCR2FRCXR;

	// PCR reads back the address of the instruction before this one
	assign pc_read = inst_pc - PC_STEP;

	free_run_counter u_frc (
		.iCLOCK     (iCLOCK),
		.inRESET    (inRESET),
		.load       (wr_frcr),
		.load_value ({frchr, frclr}),
		.count      (count)
	);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			tidr  <= '0;
			psr   <= '0;
			ppsr  <= '0;
			spr   <= '0;
			pcr   <= '0;
			frclr <= '0;
			frchr <= '0;
		end else begin
			if (sys_wr && wb.destination == SYSREG_TIDR) begin
				tidr <= wb.data;
			end
			// Interrupt entry and exit take priority over software writes
			if (irq_set) begin
				psr <= psr & ~PSR_IRQ_CLEAR_MASK;
			end else if (irq_clr) begin
				psr <= ppsr;
			end else if (sys_wr && wb.destination == SYSREG_PSR) begin
				psr <= wb.data;
			end
			if (irq_set) begin
				ppsr <= psr;
			end else if (sys_wr && wb.destination == SYSREG_PPSR) begin
				ppsr <= wb.data;
			end
			// Dedicated stack pointer writeback wins
			if (commit && wb.spr_writeback) begin
				spr <= wb.spr;
			end else if (sys_wr && wb.destination == SYSREG_SPR) begin
				spr <= wb.data;
			end
			if (commit) begin
				pcr <= wb.branch ? wb.branch_pc : wb.pc;
			end
			if (sys_wr && wb.destination == SYSREG_FRCLR) begin
				frclr <= wb.data;
			end else if (wr_snap) begin
				frclr <= count[31:0];
			end
			if (sys_wr && wb.destination == SYSREG_FRCHR) begin
				frchr <= wb.data;
			end else if (wr_snap) begin
				frchr <= count[63:32];
			end
		end
	end

	function automatic logic [32:0] read_sel(input reg_ptr_t ptr);
		logic [32:0] res;
		case (ptr)
			SYSREG_CPUIDR:  res = {1'b1, PROCESSOR_ID_REV};
			SYSREG_COREIDR: res = {1'b1, CORE_IDR};
			SYSREG_TIDR:    res = {1'b1, tidr};
			SYSREG_PCR:     res = {1'b1, pc_read};
			SYSREG_SPR:     res = {1'b1, spr};
			SYSREG_PSR:     res = {1'b1, psr};
			SYSREG_PPSR:    res = {1'b1, ppsr};
			SYSREG_FRCLR:   res = {1'b1, frclr};
			SYSREG_FRCHR:   res = {1'b1, frchr};
			default:        res = '0;
		endcase
		return res;
	endfunction

	always_comb begin
		{rd0_hit, rd0_data} = read_sel(rd0_ptr);
		{rd1_hit, rd1_data} = read_sel(rd1_ptr);
	end

	a_irq_exclusive: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		!(irq_set && irq_clr)
	);

endmodule

//--- free_run_counter.sv
module free_run_counter import dispatch_pkg::*; (
	input  logic     iCLOCK,
	input  logic     inRESET,
	input  logic     load,
	input  counter_t load_value,
	output counter_t count
);

	// Load replaces the increment on that edge
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			count <= '0;
		end else if (load) begin
			count <= load_value;
		end else begin
			count <= count + counter_t'(1);
		end
	end

endmodule

//--- gpr_file.sv
module gpr_file import dispatch_pkg::*; (
	input  logic     iCLOCK,
	input  logic     inRESET,
	wb_if.sink       wb,
	input  reg_ptr_t rd0_ptr,
	input  reg_ptr_t rd1_ptr,
	output word_t    rd0_data,
	output word_t    rd1_data
);

	word_t regs [32];
	logic  wr_en;

	assign wr_en = wb.valid && !wb.pipeline_stop && wb.writeback && !wb.dest_sysreg;

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.destination] <= wb.data;
		end
	end

	// Asynchronous read ports
	assign rd0_data = regs[rd0_ptr];
	assign rd1_data = regs[rd1_ptr];

	a_gpr_dest_known: assert property (
		@(posedge iCLOCK) disable iff (!inRESET)
		wr_en |-> !$isunknown(wb.destination)
	);

endmodule

//--- wb_if.sv
interface wb_if import dispatch_pkg::*; ();

	logic     valid;
	word_t    data;
	reg_ptr_t destination;
	logic     dest_sysreg;
	logic     writeback;
	logic     spr_writeback;
	word_t    spr;
	word_t    pc;
	logic     branch;
	word_t    branch_pc;
	logic     pipeline_stop;

	// Register files take every member
	modport sink (
		input valid, data, destination, dest_sysreg, writeback,
		input spr_writeback, spr, pc, branch, branch_pc, pipeline_stop
	);

	// Operand bypass only needs what can be forwarded
	modport bypass (
		input valid, data, destination, dest_sysreg, writeback,
		input spr_writeback, spr, pc, pipeline_stop
	);

endinterface

//--- dispatch_pkg.sv
package dispatch_pkg;

	// Data and field widths
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_ptr_t;
	typedef logic [4:0]  cmd_t;
	typedef logic [3:0]  cc_t;
	typedef logic [63:0] counter_t;

	// System register map
	localparam reg_ptr_t SYSREG_CPUIDR     = 5'd0;
	localparam reg_ptr_t SYSREG_COREIDR    = 5'd1;
	localparam reg_ptr_t SYSREG_TIDR       = 5'd2;
	localparam reg_ptr_t SYSREG_PCR        = 5'd4;
	localparam reg_ptr_t SYSREG_SPR        = 5'd5;
	localparam reg_ptr_t SYSREG_PSR        = 5'd6;
	localparam reg_ptr_t SYSREG_PPSR       = 5'd12;
	localparam reg_ptr_t SYSREG_FRCLR      = 5'd16;
	localparam reg_ptr_t SYSREG_FRCHR      = 5'd17;

	// Write-only counter commands
	localparam reg_ptr_t SYSREG_FRCR       = 5'd18;
	localparam reg_ptr_t SYSREG_FRCR2FRCXR = 5'd19;

	// Processor id in the upper half, revision in the lower half
	localparam word_t PROCESSOR_ID_REV = 32'h0002_0001;

	// PSR bits 6, 5 and 2 drop on interrupt entry
	localparam word_t PSR_IRQ_CLEAR_MASK = 32'h0000_0064;

	localparam word_t PC_STEP = 32'd4;

endpackage
